// File: hw/ifu_pkg.sv
// Shared widths, memory geometry, response codes and fetch states for the instruction fetch side
`default_nettype none

package ifu_pkg;

  // AXI-lite bus geometry
  localparam int AXI_DATA_W = 64;
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_STRB_W = AXI_DATA_W / 8;

  // One instruction is half a bus word
  localparam int INST_W = 32;

  // Instruction SRAM, 256 words of 64 bits
  localparam int MEM_DEPTH  = 256;
  localparam int MEM_IDX_W  = $clog2(MEM_DEPTH);
  localparam int BYTE_OFS_W = $clog2(AXI_STRB_W);

  // First byte address past the end of the SRAM, 2 KiB
  localparam logic [AXI_ADDR_W-1:0] MEM_BYTES = AXI_ADDR_W'(MEM_DEPTH * AXI_STRB_W);

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // PC loaded by reset
  localparam logic [AXI_ADDR_W-1:0] RESET_PC = 32'h0000_0000;

  // Fetch unit FSM
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_ADDR,
    FETCH_DATA
  } fetch_state_e;

endpackage

`default_nettype wire

// File: hw/axil_inst_sram.sv
// AXI-lite slave holding the instruction SRAM, written by the loader and read by the fetch unit
`timescale 1ns/1ps
`default_nettype none

module axil_inst_sram (
  input  logic                             i_clk,
  input  logic                             i_rst,

  // Write address channel
  input  logic                             i_awvalid,
  output logic                             o_awready,
  input  logic [ifu_pkg::AXI_ADDR_W-1:0]   i_awaddr,

  // Write data channel
  input  logic                             i_wvalid,
  output logic                             o_wready,
  input  logic [ifu_pkg::AXI_DATA_W-1:0]   i_wdata,
  input  logic [ifu_pkg::AXI_STRB_W-1:0]   i_wstrb,

  // Write response channel
  output logic                             o_bvalid,
  input  logic                             i_bready,
  output logic [1:0]                       o_bresp,

  // Read address channel
  input  logic                             i_arvalid,
  output logic                             o_arready,
  input  logic [ifu_pkg::AXI_ADDR_W-1:0]   i_araddr,

  // Read data channel
  output logic                             o_rvalid,
  input  logic                             i_rready,
  output logic [ifu_pkg::AXI_DATA_W-1:0]   o_rdata,
  output logic [1:0]                       o_rresp
);

  logic [ifu_pkg::AXI_DATA_W-1:0] mem [ifu_pkg::MEM_DEPTH];

  logic                          wr_accept;
  logic                          wr_fire;
  logic                          wr_in_range;
  logic [ifu_pkg::MEM_IDX_W-1:0] wr_idx;

  logic                          rd_accept;
  logic                          rd_fire;
  logic                          rd_in_range;
  logic [ifu_pkg::MEM_IDX_W-1:0] rd_idx;

  // Word index and range decode for both ports
  assign wr_idx = i_awaddr[ifu_pkg::MEM_IDX_W + ifu_pkg::BYTE_OFS_W - 1 : ifu_pkg::BYTE_OFS_W];
  assign rd_idx = i_araddr[ifu_pkg::MEM_IDX_W + ifu_pkg::BYTE_OFS_W - 1 : ifu_pkg::BYTE_OFS_W];
  assign wr_in_range = (i_awaddr < ifu_pkg::MEM_BYTES);
  assign rd_in_range = (i_araddr < ifu_pkg::MEM_BYTES);

  // Take a write only when both halves are present and the B slot is free
  assign wr_accept = i_awvalid && i_wvalid && (!o_bvalid || i_bready) &&
                     !o_awready && !o_wready;
  // Handshake completes in the cycle the readies are up
  assign wr_fire   = o_awready && o_wready && i_awvalid && i_wvalid;

  // One read at a time, blocked while unclaimed read data sits in R
  assign rd_accept = i_arvalid && (!o_rvalid || i_rready) && !o_arready;
  assign rd_fire   = o_arready && i_arvalid;

  // Write handshake state
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_awready <= 1'b0;
      o_wready  <= 1'b0;
      o_bvalid  <= 1'b0;
    end else begin
      o_awready <= wr_accept;
      o_wready  <= wr_accept;
      if (wr_fire) begin
        o_bvalid <= 1'b1;
      end else if (i_bready) begin
        o_bvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (wr_fire) begin
      o_bresp <= wr_in_range ? ifu_pkg::RESP_OKAY : ifu_pkg::RESP_SLVERR;
    end
  end

  // Byte lane merge, nothing stored for out-of-range addresses
  always_ff @(posedge i_clk) begin
    if (wr_fire && wr_in_range) begin
      for (int b = 0; b < ifu_pkg::AXI_STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[wr_idx][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // Read handshake state
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_arready <= 1'b0;
      o_rvalid  <= 1'b0;
    end else begin
      o_arready <= rd_accept;
      if (rd_fire) begin
        o_rvalid <= 1'b1;
      end else if (i_rready) begin
        o_rvalid <= 1'b0;
      end
    end
  end

  // Read data is captured once and held until taken
  always_ff @(posedge i_clk) begin
    if (rd_fire) begin
      if (rd_in_range) begin
        o_rdata <= mem[rd_idx];
        o_rresp <= ifu_pkg::RESP_OKAY;
      end else begin
        o_rdata <= '0;
        o_rresp <= ifu_pkg::RESP_SLVERR;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/inst_fetch.sv
// Instruction fetch unit, walks the PC and reads one instruction at a time over AXI-lite
`timescale 1ns/1ps
`default_nettype none

module inst_fetch (
  input  logic                             i_clk,
  input  logic                             i_rst,

  // Core control
  input  logic                             i_fetch_en,
  input  logic                             i_redirect,
  input  logic [ifu_pkg::AXI_ADDR_W-1:0]   i_redirect_pc,

  // AXI-lite read master
  output logic                             o_arvalid,
  input  logic                             i_arready,
  output logic [ifu_pkg::AXI_ADDR_W-1:0]   o_araddr,
  input  logic                             i_rvalid,
  output logic                             o_rready,
  input  logic [ifu_pkg::AXI_DATA_W-1:0]   i_rdata,
  input  logic [1:0]                       i_rresp,

  // Instruction out to the core
  output logic                             o_inst_valid,
  output logic [ifu_pkg::INST_W-1:0]       o_inst,
  output logic [ifu_pkg::AXI_ADDR_W-1:0]   o_inst_pc,
  output logic                             o_inst_err
);

  ifu_pkg::fetch_state_e state_q;

  logic [ifu_pkg::AXI_ADDR_W-1:0] pc_q;
  logic [ifu_pkg::AXI_ADDR_W-1:0] req_pc_q;
  logic                           discard_q;
  logic                           issue;
  logic                           rsp_fire;
  logic                           deliver;
  logic [ifu_pkg::INST_W-1:0]     inst_sel;

  // Bus address is the 64-bit word holding the requested PC
  assign o_arvalid = (state_q == ifu_pkg::FETCH_ADDR);
  assign o_araddr  = {req_pc_q[ifu_pkg::AXI_ADDR_W-1:ifu_pkg::BYTE_OFS_W],
                      ifu_pkg::BYTE_OFS_W'(0)};
  assign o_rready  = 1'b1;

  assign issue    = (state_q == ifu_pkg::FETCH_IDLE) && i_fetch_en;
  assign rsp_fire = (state_q == ifu_pkg::FETCH_DATA) && i_rvalid;
  // A redirect arriving with the response also makes it stale
  assign deliver  = rsp_fire && !discard_q && !i_redirect;

  // PC bit 2 picks the upper instruction of the word
  assign inst_sel = req_pc_q[ifu_pkg::BYTE_OFS_W-1] ?
                    i_rdata[ifu_pkg::AXI_DATA_W-1 -: ifu_pkg::INST_W] :
                    i_rdata[ifu_pkg::INST_W-1:0];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q      <= ifu_pkg::FETCH_IDLE;
      pc_q         <= ifu_pkg::RESET_PC;
      discard_q    <= 1'b0;
      o_inst_valid <= 1'b0;
    end else begin
      o_inst_valid <= deliver;

      if (i_redirect) begin
        pc_q <= i_redirect_pc;
      end else if (deliver) begin
        pc_q <= pc_q + ifu_pkg::AXI_ADDR_W'(ifu_pkg::INST_W / 8);
      end

      // Remember that the read now in flight belongs to the old stream
      if (rsp_fire) begin
        discard_q <= 1'b0;
      end else if (i_redirect && state_q != ifu_pkg::FETCH_IDLE) begin
        discard_q <= 1'b1;
      end

      case (state_q)
        ifu_pkg::FETCH_IDLE: begin
          if (i_fetch_en) begin
            state_q <= ifu_pkg::FETCH_ADDR;
          end
        end
        ifu_pkg::FETCH_ADDR: begin
          if (i_arready) begin
            state_q <= ifu_pkg::FETCH_DATA;
          end
        end
        ifu_pkg::FETCH_DATA: begin
          if (i_rvalid) begin
            state_q <= ifu_pkg::FETCH_IDLE;
          end
        end
        default: state_q <= ifu_pkg::FETCH_IDLE;
      endcase
    end
  end

  // Request address and delivered instruction payload
  always_ff @(posedge i_clk) begin
    if (issue) begin
      req_pc_q <= i_redirect ? i_redirect_pc : pc_q;
    end
    if (deliver) begin
      o_inst     <= inst_sel;
      o_inst_pc  <= req_pc_q;
      o_inst_err <= (i_rresp == ifu_pkg::RESP_SLVERR);
    end
  end

endmodule

`default_nettype wire

// File: hw/fetch_subsys_top.sv
// Fetch subsystem top, joins the fetch unit to the instruction SRAM and exposes the load port
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys_top (
  input  logic                             i_clk,
  input  logic                             i_rst,

  // Program load port, AW/W/B only
  input  logic                             i_awvalid,
  output logic                             o_awready,
  input  logic [ifu_pkg::AXI_ADDR_W-1:0]   i_awaddr,
  input  logic                             i_wvalid,
  output logic                             o_wready,
  input  logic [ifu_pkg::AXI_DATA_W-1:0]   i_wdata,
  input  logic [ifu_pkg::AXI_STRB_W-1:0]   i_wstrb,
  output logic                             o_bvalid,
  input  logic                             i_bready,
  output logic [1:0]                       o_bresp,

  // Core side
  input  logic                             i_fetch_en,
  input  logic                             i_redirect,
  input  logic [ifu_pkg::AXI_ADDR_W-1:0]   i_redirect_pc,
  output logic                             o_inst_valid,
  output logic [ifu_pkg::INST_W-1:0]       o_inst,
  output logic [ifu_pkg::AXI_ADDR_W-1:0]   o_inst_pc,
  output logic                             o_inst_err
);

  // Internal AXI-lite read channel
  logic                           arvalid;
  logic                           arready;
  logic [ifu_pkg::AXI_ADDR_W-1:0] araddr;
  logic                           rvalid;
  logic                           rready;
  logic [ifu_pkg::AXI_DATA_W-1:0] rdata;
  logic [1:0]                     rresp;

  inst_fetch i_inst_fetch (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_fetch_en    (i_fetch_en),
    .i_redirect    (i_redirect),
    .i_redirect_pc (i_redirect_pc),
    .o_arvalid     (arvalid),
    .i_arready     (arready),
    .o_araddr      (araddr),
    .i_rvalid      (rvalid),
    .o_rready      (rready),
    .i_rdata       (rdata),
    .i_rresp       (rresp),
    .o_inst_valid  (o_inst_valid),
    .o_inst        (o_inst),
    .o_inst_pc     (o_inst_pc),
    .o_inst_err    (o_inst_err)
  );

  axil_inst_sram i_axil_inst_sram (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_awvalid (i_awvalid),
    .o_awready (o_awready),
    .i_awaddr  (i_awaddr),
    .i_wvalid  (i_wvalid),
    .o_wready  (o_wready),
    .i_wdata   (i_wdata),
    .i_wstrb   (i_wstrb),
    .o_bvalid  (o_bvalid),
    .i_bready  (i_bready),
    .o_bresp   (o_bresp),
    .i_arvalid (arvalid),
    .o_arready (arready),
    .i_araddr  (araddr),
    .o_rvalid  (rvalid),
    .i_rready  (rready),
    .o_rdata   (rdata),
    .o_rresp   (rresp)
  );

endmodule

`default_nettype wire

// File: dv/fetch_subsys_props.sv
// Concurrent checks on the fetch unit's read channel and instruction output for binding into inst_fetch
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys_props (
  input logic        i_clk,
  input logic        i_rst,
  input logic        i_redirect,
  input logic        i_arvalid,
  input logic        i_arready,
  input logic [31:0] i_araddr,
  input logic        i_rvalid,
  input logic        i_inst_valid
);

  logic in_flight_q;
  logic stale_q;

  // Track a read from AR acceptance to R and note a redirect that lands on it
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      in_flight_q <= 1'b0;
      stale_q     <= 1'b0;
    end else if (i_rvalid) begin
      in_flight_q <= 1'b0;
      stale_q     <= 1'b0;
    end else begin
      if (i_arvalid && i_arready) begin
        in_flight_q <= 1'b1;
      end
      if (i_redirect && (i_arvalid || in_flight_q)) begin
        stale_q <= 1'b1;
      end
    end
  end

  // A request and its address stay put until the SRAM takes it
  a_arvalid_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_arvalid && !i_arready |=> i_arvalid && $stable(i_araddr))
    else $error("arvalid or araddr changed before arready");

  // A response made stale by a redirect never reaches the core
  a_discard_quiet: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rvalid && (stale_q || i_redirect) |=> !i_inst_valid)
    else $error("o_inst_valid pulsed for a discarded response");

  // Only one read in flight
  a_single_read: assert property (@(posedge i_clk) disable iff (i_rst)
    i_rvalid |-> !i_arvalid)
    else $error("new arvalid raised while read data is pending");

endmodule

bind inst_fetch fetch_subsys_props i_fetch_subsys_props (
  .i_clk        (i_clk),
  .i_rst        (i_rst),
  .i_redirect   (i_redirect),
  .i_arvalid    (o_arvalid),
  .i_arready    (i_arready),
  .i_araddr     (o_araddr),
  .i_rvalid     (i_rvalid),
  .i_inst_valid (o_inst_valid)
);

`default_nettype wire

// File: dv/fetch_subsys_tb.sv
// Testbench for the fetch subsystem, loads a program over the write port and checks every fetch
`timescale 1ns/1ps
`default_nettype none

module fetch_subsys_tb;

  localparam int          LOAD_WORDS = 64;
  localparam logic [31:0] MEM_BYTES  = 32'd2048;
  localparam logic [31:0] SEED       = 32'h262d_a4be;
  // About 750 cycles of traffic, with generous margin
  localparam int          WATCHDOG_CYCLES = 2000;

  logic        clk;
  logic        rst;
  logic        awvalid;
  logic [31:0] awaddr;
  logic        wvalid;
  logic [63:0] wdata;
  logic [7:0]  wstrb;
  logic        bready;
  logic        fetch_en;
  logic        redirect;
  logic [31:0] redirect_pc;
  logic        awready;
  logic        wready;
  logic        bvalid;
  logic [1:0]  bresp;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] inst_pc;
  logic        inst_err;

  // Byte image of the SRAM as written by the testbench
  logic [7:0]  model [2048];
  logic [31:0] exp_pc;
  logic [1:0]  exp_bresp;
  logic        stalled;
  int          n_errors;
  int          end_errors;
  int          n_insts;
  int          n_aw_fires;
  int          n_b_resps;

  fetch_subsys_top i_fetch_subsys_top (
    .i_clk         (clk),
    .i_rst         (rst),
    .i_awvalid     (awvalid),
    .o_awready     (awready),
    .i_awaddr      (awaddr),
    .i_wvalid      (wvalid),
    .o_wready      (wready),
    .i_wdata       (wdata),
    .i_wstrb       (wstrb),
    .o_bvalid      (bvalid),
    .i_bready      (bready),
    .o_bresp       (bresp),
    .i_fetch_en    (fetch_en),
    .i_redirect    (redirect),
    .i_redirect_pc (redirect_pc),
    .o_inst_valid  (inst_valid),
    .o_inst        (inst),
    .o_inst_pc     (inst_pc),
    .o_inst_err    (inst_err)
  );

  always #50 clk = ~clk;

  // Little-endian lanes, bytes pc..pc+3; nothing exists past the SRAM
  function automatic logic [31:0] expected_inst(input logic [31:0] pc);
    logic [10:0] a;
    a = pc[10:0];
    if (pc >= MEM_BYTES) begin
      return '0;
    end
    return {model[a + 11'd3], model[a + 11'd2], model[a + 11'd1], model[a]};
  endfunction

  task automatic write_word(input logic [31:0] addr, input logic [63:0] data,
                            input logic [7:0] strb);
    @(posedge clk);
    #1;
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    wstrb   = strb;
    do @(posedge clk); while (!(awready && wready));
    #1;
    awvalid = 1'b0;
    wvalid  = 1'b0;
    if (addr < MEM_BYTES) begin
      for (int b = 0; b < 8; b++) begin
        if (strb[b]) begin
          model[11'(addr + b)] = data[b*8 +: 8];
        end
      end
    end
    do @(posedge clk); while (!bvalid);
  endtask

  task automatic set_fetch(input logic en);
    @(posedge clk);
    #1;
    fetch_en = en;
  endtask

  task automatic wait_insts(input int n);
    int target;
    target = n_insts + n;
    while (n_insts < target) @(posedge clk);
  endtask

  // Pulse lands in the cycle after arvalid is seen, so a read is outstanding
  task automatic redirect_to(input logic [31:0] target);
    do @(posedge clk); while (!i_fetch_subsys_top.arvalid);
    #1;
    redirect    = 1'b1;
    redirect_pc = target;
    @(posedge clk);
    #1;
    redirect = 1'b0;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      exp_pc     <= 32'h0000_0000;
      n_insts    <= 0;
      n_aw_fires <= 0;
      n_b_resps  <= 0;
      n_errors = 0;
    end else begin
      if (inst_valid) begin
        assert (inst_pc === exp_pc && inst === expected_inst(exp_pc) &&
                inst_err === (exp_pc >= MEM_BYTES)) else begin
          n_errors++;
          $display("[ERROR] %0t: got pc %h inst %h err %b, expected pc %h inst %h",
                   $time, inst_pc, inst, inst_err, exp_pc, expected_inst(exp_pc));
        end
        assert (!stalled) else begin
          n_errors++;
          $display("[ERROR] %0t: pc %h delivered while fetch is disabled", $time, inst_pc);
        end
        n_insts <= n_insts + 1;
      end
      // Anything delivered up to the redirect cycle belongs to the old stream
      if (redirect) begin
        exp_pc <= redirect_pc;
      end else if (inst_valid) begin
        exp_pc <= exp_pc + 32'd4;
      end
      if (awvalid && awready && wvalid && wready) begin
        n_aw_fires <= n_aw_fires + 1;
        exp_bresp  <= (awaddr >= MEM_BYTES) ? ifu_pkg::RESP_SLVERR : ifu_pkg::RESP_OKAY;
      end
      if (bvalid && bready) begin
        n_b_resps <= n_b_resps + 1;
        assert (bresp === exp_bresp) else begin
          n_errors++;
          $display("[ERROR] %0t: bresp %b, expected %b", $time, bresp, exp_bresp);
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: the test did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    void'($urandom(SEED));
    clk         = 1'b0;
    rst         = 1'b1;
    awvalid     = 1'b0;
    awaddr      = '0;
    wvalid      = 1'b0;
    wdata       = '0;
    wstrb       = '0;
    bready      = 1'b1;
    fetch_en    = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    stalled     = 1'b0;
    end_errors  = 0;
    repeat (8) @(posedge clk);
    #1;
    rst     = 1'b0;
    stalled = 1'b1;

    for (int i = 0; i < LOAD_WORDS; i++) begin
      write_word(i * 8, {$urandom, $urandom}, 8'hff);
    end

    stalled = 1'b0;
    set_fetch(1'b1);
    wait_insts(20);

    // The fetch already in flight may still complete
    set_fetch(1'b0);
    repeat (6) @(posedge clk);
    #1;
    stalled = 1'b1;
    repeat (20) @(posedge clk);

    // Random strobes over the words about to be fetched
    for (int k = 0; k < 8; k++) begin
      write_word({exp_pc[31:3], 3'b000} + k * 8, {$urandom, $urandom}, 8'($urandom));
    end
    stalled = 1'b0;
    set_fetch(1'b1);
    wait_insts(20);

    repeat (4) begin
      redirect_to(($urandom % 32'd96) << 2);
      wait_insts(6);
    end

    // These alias words 0 to 3 if the range check were missing
    for (int k = 0; k < 4; k++) begin
      write_word(MEM_BYTES + k * 8, {$urandom, $urandom}, 8'hff);
    end
    redirect_to(MEM_BYTES + (($urandom % 32'd64) << 2));
    wait_insts(3);
    redirect_to(32'h0000_0000);
    wait_insts(8);
    set_fetch(1'b0);
    repeat (8) @(posedge clk);

    assert (n_aw_fires == n_b_resps && n_aw_fires == LOAD_WORDS + 12) else begin
      end_errors++;
      $display("Write responses do not match accepted writes: %0d accepted, %0d responses",
               n_aw_fires, n_b_resps);
    end

    $display("Instructions checked: %0d, writes: %0d, errors: %0d",
             n_insts, n_aw_fires, n_errors + end_errors);
    if (n_errors + end_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hw/ifu_pkg.sv
hw/axil_inst_sram.sv
hw/inst_fetch.sv
hw/fetch_subsys_top.sv
dv/fetch_subsys_props.sv
dv/fetch_subsys_tb.sv

// File: Makefile
SIM  := obj_dir/Vfetch_subsys_tb
SRCS := $(wildcard hw/*.sv dv/*.sv)

.PHONY: all run clean

all: run

$(SIM): project.f $(SRCS)
	verilator --binary --timing --assert -f project.f --top-module fetch_subsys_tb

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "=== FAIL ===" sim.log || grep -q "%Error" sim.log || \
	    ! grep -q "=== PASS ===" sim.log; then \
	  echo "Simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
